/* src/multicomp_pkg.sv */
`default_nettype none

package multicomp_pkg;

	// ==============================
	// Core selection
	// ==============================

	localparam int unsigned NUM_CORES = 4;

	// Menu order of the CPU/ROM choices
	typedef enum logic [1:0] {
		CPU_Z80_CPM    = 2'd0,
		CPU_Z80_BASIC  = 2'd1,
		CPU_6502_BASIC = 2'd2,
		CPU_6809_BASIC = 2'd3
	} cpu_sel_t;

	// ==============================
	// Baud rate
	// ==============================

	// Codes 6 and 7 are unused in the menu, treated as 115200
	typedef enum logic [2:0] {
		BAUD_115200 = 3'd0,
		BAUD_38400  = 3'd1,
		BAUD_19200  = 3'd2,
		BAUD_9600   = 3'd3,
		BAUD_4800   = 3'd4,
		BAUD_2400   = 3'd5
	} baud_sel_t;

	// Phase accumulator step for the core UARTs
	typedef logic [15:0] baud_inc_t;

	localparam baud_inc_t BAUD_INC_115200 = 16'd2416;
	localparam baud_inc_t BAUD_INC_38400  = 16'd805;
	localparam baud_inc_t BAUD_INC_19200  = 16'd403;
	localparam baud_inc_t BAUD_INC_9600   = 16'd201;
	localparam baud_inc_t BAUD_INC_4800   = 16'd101;
	localparam baud_inc_t BAUD_INC_2400   = 16'd50;

	// ==============================
	// Timers
	// ==============================

	localparam int unsigned MOUNT_RESET_CYCLES = 65535;
	localparam int unsigned INIT_HOLD_CYCLES   = 50000;
	localparam int unsigned SD_ACT_CYCLES      = 1000000;

	// Counter widths sized to their limits
	localparam int unsigned MOUNT_CNT_W = $clog2(MOUNT_RESET_CYCLES + 1);
	localparam int unsigned INIT_CNT_W  = $clog2(INIT_HOLD_CYCLES + 1);
	localparam int unsigned ACT_CNT_W   = $clog2(SD_ACT_CYCLES + 1);

	// ==============================
	// Bundles
	// ==============================

	// Menu configuration, held steady by the host
	typedef struct packed {
		logic      reset_req;
		cpu_sel_t  cpu;
		baud_sel_t baud;
		logic      user_port;
		logic      flow_en;
		logic      reset_on_mount;
	} menu_cfg_t;

	typedef struct packed {
		logic cs_n;
		logic sck;
		logic mosi;
	} spi_t;

	// Outputs of one CPU core
	typedef struct packed {
		spi_t spi;
		logic txd;
		logic rts;
		logic drive_led;
	} core_out_t;

	// Console UART output pins
	typedef struct packed {
		logic txd;
		logic rts;
	} serial_pins_t;

endpackage

`default_nettype wire

/* src/reset_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module reset_ctrl import multicomp_pkg::*; (
	input  wire       clk_sys,
	input  wire       RESET,
	input  wire       user_button,
	input  menu_cfg_t cfg,
	input  wire       img_mounted,
	output logic      sys_reset
);

	// Stretch flag and its cycle counter
	logic                   mount_rst;
	logic [MOUNT_CNT_W-1:0] mount_cnt;

	// Mount stretcher
	// Flag rises on the edge after the strobe
	// Held for MOUNT_RESET_CYCLES + 1 cycles in total
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			mount_rst <= 1'b0;
			mount_cnt <= '0;
		end else if (img_mounted && cfg.reset_on_mount) begin
			// A new mount restarts the count
			mount_rst <= 1'b1;
			mount_cnt <= '0;
		end else if (mount_rst) begin
			if (mount_cnt != MOUNT_CNT_W'(MOUNT_RESET_CYCLES)) begin
				mount_cnt <= mount_cnt + 1'b1;
			end else begin
				mount_rst <= 1'b0;
			end
		end
	end

	// Combine all reset sources
	// Hard reset, menu reset, board button, mount stretch
	always_comb begin
		sys_reset = RESET | cfg.reset_req | user_button | mount_rst;
	end

endmodule

`default_nettype wire

/* src/core_select.sv */
`timescale 1ns/1ps
`default_nettype none

module core_select import multicomp_pkg::*; (
	input  wire                  sys_reset,
	input  menu_cfg_t            cfg,
	input  core_out_t            core_out [NUM_CORES],
	output logic [NUM_CORES-1:0] core_run,
	output baud_inc_t            baud_inc,
	output core_out_t            sel_out
);

	// ==============================
	// Run enables
	// ==============================

	// One core runs, the rest sit in reset
	// All held off during system reset
	always_comb begin
		for (int i = 0; i < NUM_CORES; i++) begin
			core_run[i] = !sys_reset && (cfg.cpu == cpu_sel_t'(i));
		end
	end

	// ==============================
	// Baud increment table
	// ==============================

	always_comb begin
		case (cfg.baud)
			BAUD_115200: begin
				baud_inc = BAUD_INC_115200;
			end
			BAUD_38400: begin
				baud_inc = BAUD_INC_38400;
			end
			BAUD_19200: begin
				baud_inc = BAUD_INC_19200;
			end
			BAUD_9600: begin
				baud_inc = BAUD_INC_9600;
			end
			BAUD_4800: begin
				baud_inc = BAUD_INC_4800;
			end
			BAUD_2400: begin
				baud_inc = BAUD_INC_2400;
			end
			// Unused codes fall back to the fastest rate
			default: begin
				baud_inc = BAUD_INC_115200;
			end
		endcase
	end

	// ==============================
	// Output mux
	// ==============================

	// Bundle of the chosen core, SPI, serial and LED together
	always_comb begin
		sel_out = core_out[cfg.cpu];
	end

endmodule

`default_nettype wire

/* src/sd_route.sv */
`timescale 1ns/1ps
`default_nettype none

module sd_route import multicomp_pkg::*; (
	input  wire  clk_sys,
	input  wire  RESET,
	input  wire  img_mounted,
	input  wire  img_size_nz,
	input  spi_t sel_spi,
	input  wire  sd_miso_pin,
	input  wire  vsd_miso,
	output spi_t sd_pin,
	output spi_t vsd_spi,
	output logic sd_miso_core,
	output logic sd_active,
	output logic vsd_sel
);

	logic                 old_mosi;
	logic                 old_miso;
	logic                 spi_edge;
	logic [ACT_CNT_W-1:0] act_cnt;

	// Card choice latched on each mount
	// Only a hard reset goes back to the physical slot
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			vsd_sel <= 1'b0;
		end else if (img_mounted) begin
			vsd_sel <= img_size_nz;
		end
	end

	// ==============================
	// SPI routing
	// ==============================

	always_comb begin
		// Physical slot idles while the image card is in use
		sd_pin.cs_n  = sel_spi.cs_n | vsd_sel;
		sd_pin.sck   = sel_spi.sck & ~vsd_sel;
		sd_pin.mosi  = sel_spi.mosi & ~vsd_sel;
		// Image card deselected otherwise
		vsd_spi.cs_n = sel_spi.cs_n | ~vsd_sel;
		vsd_spi.sck  = sel_spi.sck;
		vsd_spi.mosi = sel_spi.mosi;
		// MISO from whichever side is active
		sd_miso_core = vsd_sel ? vsd_miso : sd_miso_pin;
	end

	// ==============================
	// Activity indicator
	// ==============================

	// Toggle detect on both data lines
	always_ff @(posedge clk_sys) begin
		old_mosi <= sel_spi.mosi;
		old_miso <= sd_miso_core;
	end

	assign spi_edge = (old_mosi ^ sel_spi.mosi) | (old_miso ^ sd_miso_core);

	// Hold counter restarts on every data edge
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			act_cnt   <= '0;
			sd_active <= 1'b0;
		end else begin
			sd_active <= act_cnt < ACT_CNT_W'(SD_ACT_CYCLES);
			if (spi_edge) begin
				act_cnt <= '0;
			end else if (act_cnt < ACT_CNT_W'(SD_ACT_CYCLES)) begin
				act_cnt <= act_cnt + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

/* src/serial_route.sv */
`timescale 1ns/1ps
`default_nettype none

module serial_route import multicomp_pkg::*; (
	input  wire          clk_sys,
	input  wire          sys_reset,
	input  menu_cfg_t    cfg,
	input  wire          sel_txd,
	input  wire          sel_rts,
	input  wire          uart_rxd,
	input  wire          uart_cts,
	input  wire  [6:0]   user_in,
	output logic         serial_rx,
	output logic         serial_cts,
	output serial_pins_t uart_pins,
	output logic [6:0]   user_out
);

	logic                  init_done;
	logic [INIT_CNT_W-1:0] init_cnt;
	logic                  user_flow;

	// ==============================
	// CTS start-up hold-off
	// ==============================

	// Counts up after every reset
	// Done INIT_HOLD_CYCLES + 1 cycles after reset falls
	always_ff @(posedge clk_sys) begin
		if (sys_reset) begin
			init_done <= 1'b0;
			init_cnt  <= '0;
		end else if (!init_done) begin
			if (init_cnt == INIT_CNT_W'(INIT_HOLD_CYCLES)) begin
				init_done <= 1'b1;
			end else begin
				init_cnt <= init_cnt + 1'b1;
			end
		end
	end

	// Flow control active on the user port
	assign user_flow = cfg.user_port && cfg.flow_en;

	// ==============================
	// Pin routing
	// ==============================

	always_comb begin
		// User port RX sits on bit 0
		serial_rx = cfg.user_port ? user_in[0] : uart_rxd;

		// CTS low while disabled or still holding off
		serial_cts = 1'b0;
		if (cfg.flow_en && init_done) begin
			serial_cts = cfg.user_port ? user_in[3] : uart_cts;
		end

		// Console pins idle high when not in use
		uart_pins.txd = cfg.user_port ? 1'b1 : sel_txd;
		uart_pins.rts = (cfg.user_port || !cfg.flow_en) ? 1'b1 : sel_rts;

		// User port, open drain, 1 releases the line
		user_out[0]   = cfg.user_port;
		user_out[1]   = cfg.user_port ? sel_txd : 1'b1;
		user_out[2]   = user_flow ? sel_rts : 1'b1;
		user_out[3]   = user_flow;
		user_out[6:4] = 3'b000;
	end

endmodule

`default_nettype wire

/* src/multicomp_glue.sv */
`timescale 1ns/1ps
`default_nettype none

module multicomp_glue import multicomp_pkg::*; (
	input  wire                  clk_sys,
	input  wire                  RESET,
	input  wire                  user_button,
	input  menu_cfg_t            cfg,
	input  wire                  img_mounted,
	input  wire                  img_size_nz,
	input  core_out_t            core_out [NUM_CORES],
	input  wire                  sd_miso_pin,
	input  wire                  vsd_miso,
	input  wire                  uart_rxd,
	input  wire                  uart_cts,
	input  wire  [6:0]           user_in,
	output logic [NUM_CORES-1:0] core_run,
	output baud_inc_t            baud_inc,
	output logic                 sd_miso_core,
	output logic                 serial_rx,
	output logic                 serial_cts,
	output spi_t                 sd_pin,
	output spi_t                 vsd_spi,
	output serial_pins_t         uart_pins,
	output logic [6:0]           user_out,
	output logic                 drive_led,
	output logic                 sd_active,
	output logic                 vsd_sel
);

	// Combined reset for cores and serial
	logic      sys_reset;
	// Outputs of the running core
	core_out_t sel_out;

	// ==============================
	// Reset and core control
	// ==============================

	reset_ctrl u_reset_ctrl (
		.clk_sys     (clk_sys),
		.RESET       (RESET),
		.user_button (user_button),
		.cfg         (cfg),
		.img_mounted (img_mounted),
		.sys_reset   (sys_reset)
	);

	core_select u_core_select (
		.sys_reset (sys_reset),
		.cfg       (cfg),
		.core_out  (core_out),
		.core_run  (core_run),
		.baud_inc  (baud_inc),
		.sel_out   (sel_out)
	);

	assign drive_led = sel_out.drive_led;

	// ==============================
	// Pin routing
	// ==============================

	// Hard reset only, card choice survives soft resets
	sd_route u_sd_route (
		.clk_sys      (clk_sys),
		.RESET        (RESET),
		.img_mounted  (img_mounted),
		.img_size_nz  (img_size_nz),
		.sel_spi      (sel_out.spi),
		.sd_miso_pin  (sd_miso_pin),
		.vsd_miso     (vsd_miso),
		.sd_pin       (sd_pin),
		.vsd_spi      (vsd_spi),
		.sd_miso_core (sd_miso_core),
		.sd_active    (sd_active),
		.vsd_sel      (vsd_sel)
	);

	serial_route u_serial_route (
		.clk_sys    (clk_sys),
		.sys_reset  (sys_reset),
		.cfg        (cfg),
		.sel_txd    (sel_out.txd),
		.sel_rts    (sel_out.rts),
		.uart_rxd   (uart_rxd),
		.uart_cts   (uart_cts),
		.user_in    (user_in),
		.serial_rx  (serial_rx),
		.serial_cts (serial_cts),
		.uart_pins  (uart_pins),
		.user_out   (user_out)
	);

endmodule

`default_nettype wire

/* test/multicomp_glue_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module multicomp_glue_sva import multicomp_pkg::*; (
	input  wire                 clk_sys,
	input  wire                 sys_reset,
	input  wire [NUM_CORES-1:0] core_run,
	input  wire                 vsd_sel,
	input  spi_t                sd_pin
);

	// At most one core running
	assert property (@(posedge clk_sys) $onehot0(core_run))
		else $error("core_run has more than one core enabled: %b", core_run);

	// Every core held while the system reset is up
	assert property (@(posedge clk_sys) sys_reset |-> core_run == '0)
		else $error("core_run not zero during system reset: %b", core_run);

	// Physical card deselected while the image card owns the bus
	assert property (@(posedge clk_sys) vsd_sel |-> sd_pin.cs_n)
		else $error("physical SD chip select active with the image card selected");

endmodule

// Checker on every glue instance
bind multicomp_glue multicomp_glue_sva u_sva (
	.clk_sys   (clk_sys),
	.sys_reset (sys_reset),
	.core_run  (core_run),
	.vsd_sel   (vsd_sel),
	.sd_pin    (sd_pin)
);

`default_nettype wire

/* test/tb_multicomp_glue.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_multicomp_glue import multicomp_pkg::*; ();

	// ==============================
	// DUT signals
	// ==============================

	logic                 clk_sys;
	logic                 RESET;
	logic                 user_button;
	menu_cfg_t            cfg;
	logic                 img_mounted;
	logic                 img_size_nz;
	core_out_t            core_out [NUM_CORES];
	logic                 sd_miso_pin;
	logic                 vsd_miso;
	logic                 uart_rxd;
	logic                 uart_cts;
	logic [6:0]           user_in;
	logic [NUM_CORES-1:0] core_run;
	baud_inc_t            baud_inc;
	logic                 sd_miso_core;
	logic                 serial_rx;
	logic                 serial_cts;
	spi_t                 sd_pin;
	spi_t                 vsd_spi;
	serial_pins_t         uart_pins;
	logic [6:0]           user_out;
	logic                 drive_led;
	logic                 sd_active;
	logic                 vsd_sel;

	int unsigned error_count;
	int unsigned check_count;
	logic [31:0] rng_state;

	multicomp_glue dut (.*);

	// 4 ns period
	always #2 clk_sys = ~clk_sys;

	// ==============================
	// Helpers and checks
	// ==============================

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Step to 1 ns past the next rising edge
	task automatic next_cycle();
		@(posedge clk_sys);
		#1;
	endtask

	// Fresh random bundle for every core
	task automatic shuffle_cores();
		for (int i = 0; i < NUM_CORES; i++) begin
			rng_state = xorshift(rng_state);
			core_out[i] = rng_state[5:0];
		end
	endtask

	task automatic check_bundle(input core_out_t got, input core_out_t exp, input string what);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("FAILED @%0t: %s got %b expected %b", $time, what, got, exp);
		end
	endtask

	task automatic check_spi(input spi_t got, input spi_t exp, input string what);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("FAILED @%0t: %s got %b expected %b", $time, what, got, exp);
		end
	endtask

	task automatic check_baud(input baud_inc_t got, input baud_inc_t exp, input string what);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("FAILED @%0t: %s got %0d expected %0d", $time, what, got, exp);
		end
	endtask

	// Control bits and small vectors zero extended to 8 bits
	task automatic check_ctrl(input logic [7:0] got, input logic [7:0] exp, input string what);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("FAILED @%0t: %s got %b expected %b", $time, what, got, exp);
		end
	endtask

	// Increment table from the menu definition
	function automatic baud_inc_t expected_baud(input int code);
		case (code)
			1: return BAUD_INC_38400;
			2: return BAUD_INC_19200;
			3: return BAUD_INC_9600;
			4: return BAUD_INC_4800;
			5: return BAUD_INC_2400;
			default: return BAUD_INC_115200;
		endcase
	endfunction

	// One-cycle image mount strobe
	task automatic pulse_mount(input logic nz);
		img_size_nz = nz;
		img_mounted = 1'b1;
		next_cycle();
		img_mounted = 1'b0;
	endtask

	// ==============================
	// Directed tests
	// ==============================

	task automatic test_core_select();
		core_out_t seen;
		// Console port with flow control so RTS shows the core
		cfg.user_port = 1'b0;
		cfg.flow_en = 1'b1;
		for (int i = 0; i < NUM_CORES; i++) begin
			shuffle_cores();
			cfg.cpu = cpu_sel_t'(i);
			#1;
			seen = {sd_pin, uart_pins.txd, uart_pins.rts, drive_led};
			check_ctrl(8'(core_run), 8'(1) << i, $sformatf("core_run for cpu %0d", i));
			check_bundle(seen, core_out[i], $sformatf("outputs of cpu %0d", i));
			next_cycle();
		end
	endtask

	task automatic test_baud_table();
		for (int b = 0; b < 8; b++) begin
			cfg.baud = baud_sel_t'(3'(b));
			#1;
			check_baud(baud_inc, expected_baud(b), $sformatf("baud code %0d", b));
			next_cycle();
		end
	endtask

	task automatic test_mount_reset();
		int unsigned n;
		cfg.reset_on_mount = 1'b1;
		pulse_mount(1'b0);
		#1;
		check_ctrl(8'(core_run), 8'h00, "core_run during mount reset");
		n = 0;
		while (core_run == '0 && n < MOUNT_RESET_CYCLES + 4) begin
			next_cycle();
			n++;
		end
		if (core_run == '0) begin
			error_count++;
			$display("Timeout: cores still held %0d cycles after the mount", n);
		end
		check_ctrl(8'(core_run), 8'(1) << cfg.cpu, "core_run after mount reset");
		// No stretch without reset_on_mount
		cfg.reset_on_mount = 1'b0;
		pulse_mount(1'b0);
		#1;
		check_ctrl(8'(core_run), 8'(1) << cfg.cpu, "core_run after plain mount");
		next_cycle();
	endtask

	task automatic test_sd_route();
		spi_t        idle;
		spi_t        vsd_off;
		int unsigned n;
		idle = '{cs_n: 1'b1, sck: 1'b0, mosi: 1'b0};
		sd_miso_pin = 1'b0;
		vsd_miso = 1'b1;
		pulse_mount(1'b1);
		#1;
		check_ctrl(8'(vsd_sel), 8'h01, "vsd_sel after image mount");
		check_spi(sd_pin, idle, "SD pins with image card");
		check_spi(vsd_spi, core_out[cfg.cpu].spi, "image card SPI");
		check_ctrl(8'(sd_miso_core), 8'h01, "MISO from image card high");
		vsd_miso = 1'b0;
		sd_miso_pin = 1'b1;
		#1;
		check_ctrl(8'(sd_miso_core), 8'h00, "MISO from image card low");
		next_cycle();
		// Empty image goes back to the slot
		pulse_mount(1'b0);
		#1;
		vsd_off = core_out[cfg.cpu].spi;
		vsd_off.cs_n = 1'b1;
		check_ctrl(8'(vsd_sel), 8'h00, "vsd_sel after empty mount");
		check_spi(sd_pin, core_out[cfg.cpu].spi, "SD pins with physical card");
		check_spi(vsd_spi, vsd_off, "image card deselected");
		check_ctrl(8'(sd_miso_core), 8'h01, "MISO from physical card");
		next_cycle();
		// Activity lamp goes out once the bus is quiet
		n = 0;
		while (sd_active == 1'b1 && n < SD_ACT_CYCLES + 10) begin
			next_cycle();
			n++;
		end
		if (sd_active == 1'b1) begin
			error_count++;
			$display("Timeout: sd_active still high %0d cycles after the last SPI edge", n);
		end
		// A MISO edge lights it again
		sd_miso_pin = 1'b0;
		n = 0;
		while (sd_active == 1'b0 && n < 4) begin
			next_cycle();
			n++;
		end
		if (sd_active == 1'b0) begin
			error_count++;
			$display("Timeout: sd_active did not rise after a MISO edge");
		end
	endtask

	task automatic test_serial();
		int unsigned  n;
		logic         up;
		logic         fl;
		logic         exp_rx;
		logic         exp_cts;
		serial_pins_t exp_pins;
		logic [6:0]   exp_user;
		core_out_t    sel;
		cfg.user_port = 1'b0;
		cfg.flow_en = 1'b1;
		uart_cts = 1'b1;
		// Button press restarts the CTS hold-off
		user_button = 1'b1;
		next_cycle();
		user_button = 1'b0;
		n = 0;
		while (serial_cts == 1'b0 && n < INIT_HOLD_CYCLES + 10) begin
			next_cycle();
			n++;
		end
		if (serial_cts == 1'b0) begin
			error_count++;
			$display("Timeout: serial_cts still low %0d cycles after reset", n);
		end else if (n != INIT_HOLD_CYCLES + 1) begin
			error_count++;
			$display("FAILED @%0t: serial_cts rose after %0d cycles", $time, n);
		end
		// Both ports and both flow settings with random pin levels
		for (int p = 0; p < 2; p++) begin
			for (int f = 0; f < 2; f++) begin
				for (int t = 0; t < 4; t++) begin
					shuffle_cores();
					rng_state = xorshift(rng_state);
					user_in = rng_state[6:0];
					uart_rxd = rng_state[7];
					uart_cts = rng_state[8];
					up = p[0];
					fl = f[0];
					cfg.user_port = up;
					cfg.flow_en = fl;
					#1;
					sel = core_out[cfg.cpu];
					exp_rx = up ? user_in[0] : uart_rxd;
					exp_cts = fl && (up ? user_in[3] : uart_cts);
					exp_pins.txd = up ? 1'b1 : sel.txd;
					exp_pins.rts = (up || !fl) ? 1'b1 : sel.rts;
					exp_user = {3'b000, up && fl, (up && fl) ? sel.rts : 1'b1,
						up ? sel.txd : 1'b1, up};
					check_ctrl({4'b0, serial_rx, serial_cts, uart_pins},
						{4'b0, exp_rx, exp_cts, exp_pins},
						$sformatf("serial pins port %0d flow %0d", p, f));
					check_ctrl({1'b0, user_out}, {1'b0, exp_user},
						$sformatf("user_out port %0d flow %0d", p, f));
					next_cycle();
				end
			end
		end
	endtask

	// ==============================
	// Main sequence
	// ==============================

	initial begin
		clk_sys = 1'b0;
		RESET = 1'b1;
		user_button = 1'b0;
		cfg = '0;
		img_mounted = 1'b0;
		img_size_nz = 1'b0;
		for (int i = 0; i < NUM_CORES; i++) begin
			core_out[i] = '0;
		end
		sd_miso_pin = 1'b0;
		vsd_miso = 1'b0;
		uart_rxd = 1'b1;
		uart_cts = 1'b0;
		user_in = '0;
		error_count = 0;
		check_count = 0;
		rng_state = 32'h1061;

		repeat (10) @(posedge clk_sys);
		#1;
		RESET = 1'b0;

		test_core_select();
		test_baud_table();
		test_mount_reset();
		test_sd_route();
		test_serial();

		$display("Summary: %0d checks, %0d errors", check_count, error_count);
		if (error_count == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* flist.f */
src/multicomp_pkg.sv
src/reset_ctrl.sv
src/core_select.sv
src/sd_route.sv
src/serial_route.sv
src/multicomp_glue.sv
test/multicomp_glue_sva.sv
test/tb_multicomp_glue.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the glue testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 \
	--top-module tb_multicomp_glue -f flist.f -o tb_multicomp_glue
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_multicomp_glue > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qF '*** TEST PASSED ***' "$LOG"; then
	echo "Result: pass"
	exit 0
fi

echo "Result: fail"
exit 1
